/* verilog/configure.sv */
package configure;

  typedef logic [31 : 0] word_t;
  typedef logic [4  : 0] reg_addr_t;
  typedef logic [3  : 0] strb_t;
  typedef logic [3  : 0] alu_op_t;
  typedef logic [2  : 0] op_class_t;

  localparam word_t reset_vector = 32'h0000_0000; // first fetch address.

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_SLT  = 4'd5;
  localparam alu_op_t ALU_SLTU = 4'd6;
  localparam alu_op_t ALU_SLL  = 4'd7;
  localparam alu_op_t ALU_SRL  = 4'd8;
  localparam alu_op_t ALU_SRA  = 4'd9;

  localparam op_class_t OP_NONE   = 3'd0; // unsupported encodings end up here.
  localparam op_class_t OP_ALU    = 3'd1;
  localparam op_class_t OP_LUI    = 3'd2;
  localparam op_class_t OP_LOAD   = 3'd3;
  localparam op_class_t OP_STORE  = 3'd4;
  localparam op_class_t OP_BRANCH = 3'd5;
  localparam op_class_t OP_JAL    = 3'd6;

  localparam logic [6 : 0] OPC_LUI    = 7'b0110111;
  localparam logic [6 : 0] OPC_JAL    = 7'b1101111;
  localparam logic [6 : 0] OPC_BRANCH = 7'b1100011;
  localparam logic [6 : 0] OPC_LOAD   = 7'b0000011;
  localparam logic [6 : 0] OPC_STORE  = 7'b0100011;
  localparam logic [6 : 0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6 : 0] OPC_OP     = 7'b0110011;

endpackage

/* verilog/mem_if.sv */
interface mem_if
  import configure::*;
();
  logic  valid;
  logic  instr;
  word_t addr;
  word_t wdata;
  strb_t wstrb; // zero on reads.
  word_t rdata;
  logic  ready;

  modport master (output valid, instr, addr, wdata, wstrb, input rdata, ready);
  modport slave (input valid, instr, addr, wdata, wstrb, output rdata, ready);

endinterface

/* verilog/decode_if.sv */
interface decode_if
  import configure::*;
();
  op_class_t    op_class;
  alu_op_t      alu_op;
  reg_addr_t    rd;
  reg_addr_t    rs1;
  reg_addr_t    rs2;
  word_t        imm;
  logic         use_imm;
  logic [2 : 0] funct3;
  logic         branch_ne;

  modport master (
    output op_class, alu_op, rd, rs1, rs2, imm, use_imm, funct3, branch_ne
  );
  modport slave (
    input op_class, alu_op, rd, rs1, rs2, imm, use_imm, funct3, branch_ne
  );

endinterface

/* verilog/decoder.sv */
module decoder
  import configure::*;
(
  input  word_t    instr,
  decode_if.master decode
);
  logic [6 : 0] opcode;
  logic [2 : 0] funct3;
  logic         alt;
  alu_op_t      alu_func;
  word_t        imm_i;
  word_t        imm_s;
  word_t        imm_b;
  word_t        imm_j;
  word_t        imm_u;

  assign opcode = instr[6 : 0];
  assign funct3 = instr[14 : 12];
  assign alt = instr[30]; // funct7 bit selecting sub and sra.

  assign imm_i = {{20{instr[31]}}, instr[31 : 20]};
  assign imm_s = {{20{instr[31]}}, instr[31 : 25], instr[11 : 7]};
  assign imm_b = {{20{instr[31]}}, instr[7], instr[30 : 25], instr[11 : 8], 1'b0};
  assign imm_j = {{12{instr[31]}}, instr[19 : 12], instr[20], instr[30 : 21], 1'b0};
  assign imm_u = {instr[31 : 12], 12'b0};

  assign decode.rd = instr[11 : 7];
  assign decode.rs1 = instr[19 : 15];
  assign decode.rs2 = instr[24 : 20];
  assign decode.funct3 = funct3;
  assign decode.branch_ne = funct3[0];

  always_comb begin
    case (funct3)
      3'b000: alu_func = (opcode == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
      3'b001: alu_func = ALU_SLL;
      3'b010: alu_func = ALU_SLT;
      3'b011: alu_func = ALU_SLTU;
      3'b100: alu_func = ALU_XOR;
      3'b101: alu_func = alt ? ALU_SRA : ALU_SRL;
      3'b110: alu_func = ALU_OR;
      default: alu_func = ALU_AND;
    endcase
  end

  always_comb begin
    decode.op_class = OP_NONE;
    decode.alu_op = ALU_ADD; // address add for loads and stores.
    decode.imm = imm_i;
    decode.use_imm = 1'b1;
    case (opcode)
      OPC_OP: begin
        decode.op_class = OP_ALU;
        decode.alu_op = alu_func;
        decode.use_imm = 1'b0;
      end
      OPC_OP_IMM: begin
        decode.op_class = OP_ALU;
        decode.alu_op = alu_func;
      end
      OPC_LUI: begin
        decode.op_class = OP_LUI;
        decode.imm = imm_u;
      end
      OPC_JAL: begin
        decode.op_class = OP_JAL;
        decode.imm = imm_j;
      end
      OPC_LOAD: begin
        if (funct3 == 3'b000 || funct3 == 3'b010 || funct3 == 3'b100) begin
          decode.op_class = OP_LOAD;
        end
      end
      OPC_STORE: begin
        decode.imm = imm_s;
        if (funct3 == 3'b000 || funct3 == 3'b010) begin
          decode.op_class = OP_STORE;
        end
      end
      OPC_BRANCH: begin
        decode.alu_op = ALU_SUB; // compare through the equal flag.
        decode.imm = imm_b;
        decode.use_imm = 1'b0;
        if (funct3[2 : 1] == 2'b00) begin
          decode.op_class = OP_BRANCH;
        end
      end
      default: begin
        decode.op_class = OP_NONE;
      end
    endcase
  end

endmodule

/* verilog/alu.sv */
module alu
  import configure::*;
(
  input  alu_op_t op,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output logic    equal
);

  always_comb begin
    case (op)
      ALU_ADD: result = a + b;
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR: result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: result = {31'b0, a < b};
      ALU_SLL: result = a << b[4 : 0];
      ALU_SRL: result = a >> b[4 : 0];
      ALU_SRA: result = word_t'($signed(a) >>> b[4 : 0]); // keeps the sign.
      default: result = '0;
    endcase
  end

  assign equal = (a == b);

endmodule

/* verilog/register.sv */
module register
  import configure::*;
(
  input  logic      clock,
  input  logic      arst_n,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  logic      rd_write,
  input  reg_addr_t rd_addr,
  input  word_t     rd_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);
  word_t regs [1 : 31]; // x0 has no storage.

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_write && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* verilog/lsu.sv */
module lsu
  import configure::*;
(
  input  logic         clock,
  input  logic         arst_n,
  input  logic         start,
  input  logic         load,
  input  word_t        addr,
  input  word_t        wdata,
  input  logic [2 : 0] funct3,
  output logic         done,
  output word_t        load_data,
  mem_if.master        dmem
);
  logic         valid;
  word_t        bus_addr;
  word_t        bus_wdata;
  strb_t        bus_wstrb;
  logic [1 : 0] offset;
  logic [2 : 0] size;
  logic [7 : 0] byte_data;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid <= 1'b0;
    end else if (start) begin
      valid <= 1'b1;
    end else if (done) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      bus_addr <= {addr[31 : 2], 2'b00};
      offset <= addr[1 : 0];
      size <= funct3;
      if (load) begin
        bus_wstrb <= '0;
        bus_wdata <= wdata;
      end else if (funct3[1 : 0] == 2'b00) begin
        bus_wstrb <= strb_t'(4'b0001 << addr[1 : 0]); // one lane for sb.
        bus_wdata <= {4{wdata[7 : 0]}};
      end else begin
        bus_wstrb <= 4'b1111;
        bus_wdata <= wdata;
      end
    end
  end

  assign done = valid & dmem.ready;
  assign byte_data = dmem.rdata[{offset, 3'b000} +: 8];

  always_comb begin
    case (size)
      3'b000: load_data = {{24{byte_data[7]}}, byte_data}; // lb.
      3'b100: load_data = {24'b0, byte_data}; // lbu.
      default: load_data = dmem.rdata;
    endcase
  end

  assign dmem.valid = valid;
  assign dmem.instr = 1'b0;
  assign dmem.addr = bus_addr;
  assign dmem.wdata = bus_wdata;
  assign dmem.wstrb = bus_wstrb;

endmodule

/* verilog/sequencer.sv */
module sequencer
  import configure::*;
(
  input  logic         clock,
  input  logic         arst_n,
  mem_if.master        imem,
  decode_if.slave      decode,
  output word_t        instr,
  output alu_op_t      alu_op,
  output word_t        alu_a,
  output word_t        alu_b,
  input  word_t        alu_result,
  input  logic         alu_equal,
  output reg_addr_t    rs1_addr,
  output reg_addr_t    rs2_addr,
  input  word_t        rs1_data,
  input  word_t        rs2_data,
  output logic         rd_write,
  output reg_addr_t    rd_addr,
  output word_t        rd_data,
  output logic         lsu_start,
  output logic         lsu_load,
  output word_t        lsu_addr,
  output word_t        lsu_wdata,
  output logic [2 : 0] lsu_funct3,
  input  logic         lsu_done,
  input  word_t        load_data
);
  typedef enum logic [1 : 0] {START, FETCH, EXECUTE, MEMORY} state_t;

  state_t state;
  state_t state_next;
  word_t  pc;
  word_t  pc_next;
  word_t  pc_plus4;
  word_t  pc_target;
  logic   taken;

  assign imem.valid = (state == FETCH);
  assign imem.instr = (state == FETCH);
  assign imem.addr = pc;
  assign imem.wdata = '0;
  assign imem.wstrb = '0; // fetches never write.

  assign alu_op = decode.alu_op;
  assign alu_a = rs1_data;
  assign alu_b = decode.use_imm ? decode.imm : rs2_data;
  assign rs1_addr = decode.rs1;
  assign rs2_addr = decode.rs2;
  assign rd_addr = decode.rd;

  assign lsu_load = (decode.op_class == OP_LOAD);
  assign lsu_addr = alu_result;
  assign lsu_wdata = rs2_data;
  assign lsu_funct3 = decode.funct3;

  assign pc_plus4 = pc + 32'd4;
  assign pc_target = pc + decode.imm;
  assign taken = alu_equal ^ decode.branch_ne;

  always_comb begin
    state_next = state;
    pc_next = pc;
    rd_write = 1'b0;
    rd_data = alu_result;
    lsu_start = 1'b0;
    case (state)
      START: state_next = FETCH;
      FETCH: begin
        if (imem.ready) begin
          state_next = EXECUTE;
        end
      end
      EXECUTE: begin
        state_next = FETCH;
        pc_next = pc_plus4;
        case (decode.op_class)
          OP_ALU: rd_write = 1'b1;
          OP_LUI: begin
            rd_write = 1'b1;
            rd_data = decode.imm;
          end
          OP_JAL: begin
            rd_write = 1'b1;
            rd_data = pc_plus4; // link address.
            pc_next = pc_target;
          end
          OP_BRANCH: pc_next = taken ? pc_target : pc_plus4;
          OP_LOAD, OP_STORE: begin
            lsu_start = 1'b1;
            state_next = MEMORY;
            pc_next = pc; // pc moves on once the access completes.
          end
          default: pc_next = pc_plus4;
        endcase
      end
      MEMORY: begin
        rd_data = load_data;
        if (lsu_done) begin
          rd_write = lsu_load;
          pc_next = pc_plus4;
          state_next = FETCH;
        end
      end
      default: state_next = FETCH;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state <= START;
      pc <= reset_vector;
    end else begin
      state <= state_next;
      pc <= pc_next;
    end
  end

  always_ff @(posedge clock) begin
    if (state == FETCH && imem.ready) begin
      instr <= imem.rdata;
    end
  end

endmodule

/* verilog/cpu.sv */
module cpu
  import configure::*;
(
  input  logic  clock,
  input  logic  arst_n,
  output logic  imemory_valid,
  output logic  imemory_instr,
  output word_t imemory_addr,
  output word_t imemory_wdata,
  output strb_t imemory_wstrb,
  input  word_t imemory_rdata,
  input  logic  imemory_ready,
  output logic  dmemory_valid,
  output logic  dmemory_instr,
  output word_t dmemory_addr,
  output word_t dmemory_wdata,
  output strb_t dmemory_wstrb,
  input  word_t dmemory_rdata,
  input  logic  dmemory_ready
);
  word_t        instr;
  alu_op_t      alu_op;
  word_t        alu_a;
  word_t        alu_b;
  word_t        alu_result;
  logic         alu_equal;
  reg_addr_t    rs1_addr;
  reg_addr_t    rs2_addr;
  word_t        rs1_data;
  word_t        rs2_data;
  logic         rd_write;
  reg_addr_t    rd_addr;
  word_t        rd_data;
  logic         lsu_start;
  logic         lsu_load;
  word_t        lsu_addr;
  word_t        lsu_wdata;
  logic [2 : 0] lsu_funct3;
  logic         lsu_done;
  word_t        load_data;

  mem_if imem ();
  mem_if dmem ();
  decode_if decode ();

  sequencer sequencer_comp
  (
    .imem (imem),
    .decode (decode),
    .*
  );

  decoder decoder_comp
  (
    .instr (instr),
    .decode (decode)
  );

  alu alu_comp
  (
    .op (alu_op),
    .a (alu_a),
    .b (alu_b),
    .result (alu_result),
    .equal (alu_equal)
  );

  register register_comp
  (
    .*
  );

  lsu lsu_comp
  (
    .clock (clock),
    .arst_n (arst_n),
    .start (lsu_start),
    .load (lsu_load),
    .addr (lsu_addr),
    .wdata (lsu_wdata),
    .funct3 (lsu_funct3),
    .done (lsu_done),
    .load_data (load_data),
    .dmem (dmem)
  );

  assign imemory_valid = imem.valid;
  assign imemory_instr = imem.instr;
  assign imemory_addr = imem.addr;
  assign imemory_wdata = imem.wdata;
  assign imemory_wstrb = imem.wstrb;
  assign imem.rdata = imemory_rdata;
  assign imem.ready = imemory_ready;

  assign dmemory_valid = dmem.valid;
  assign dmemory_instr = dmem.instr;
  assign dmemory_addr = dmem.addr;
  assign dmemory_wdata = dmem.wdata;
  assign dmemory_wstrb = dmem.wstrb;
  assign dmem.rdata = dmemory_rdata;
  assign dmem.ready = dmemory_ready;

endmodule

/* verif/cpu_props.sv */
module cpu_props
  import configure::*;
(
  input logic  clock,
  input logic  arst_n,
  input logic  imemory_valid,
  input logic  imemory_instr,
  input word_t imemory_addr,
  input logic  imemory_ready,
  input logic  dmemory_valid,
  input word_t dmemory_addr,
  input strb_t dmemory_wstrb,
  input logic  dmemory_ready,
  input logic  lsu_load
);
  timeunit 1ns;
  timeprecision 1ps;

  imem_hold: assert property (@(posedge clock) disable iff (!arst_n)
    imemory_valid && !imemory_ready |=> imemory_valid && $stable(imemory_addr))
    else $error("instruction request dropped or moved before ready");

  dmem_hold: assert property (@(posedge clock) disable iff (!arst_n)
    dmemory_valid && !dmemory_ready |=> dmemory_valid && $stable(dmemory_addr))
    else $error("data request dropped or moved before ready");

  one_bus: assert property (@(posedge clock) disable iff (!arst_n)
    !(imemory_valid && dmemory_valid))
    else $error("both buses valid in one cycle");

  fetch_flag: assert property (@(posedge clock) disable iff (!arst_n)
    imemory_valid |-> imemory_instr)
    else $error("instruction fetch without instr");

  read_strobe: assert property (@(posedge clock) disable iff (!arst_n)
    dmemory_valid && lsu_load |-> dmemory_wstrb == '0)
    else $error("load issued with a write strobe");

endmodule

bind cpu cpu_props cpu_props_inst (
  .clock (clock),
  .arst_n (arst_n),
  .imemory_valid (imemory_valid),
  .imemory_instr (imemory_instr),
  .imemory_addr (imemory_addr),
  .imemory_ready (imemory_ready),
  .dmemory_valid (dmemory_valid),
  .dmemory_addr (dmemory_addr),
  .dmemory_wstrb (dmemory_wstrb),
  .dmemory_ready (dmemory_ready),
  .lsu_load (lsu_load)
);

/* verif/cpu_tb.sv */
module cpu_tb
  import configure::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam word_t        data_base = 32'h0000_0400;
  localparam word_t        marker_addr = 32'h0000_0ffc;
  localparam logic [6 : 0] opc_imm = 7'b0010011;
  localparam logic [6 : 0] opc_load = 7'b0000011;
  localparam int           watchdog_ns = 20000; // some 170 instructions at 12 cycles each.

  logic  clock = 1'b0;
  logic  arst_n;
  logic  imemory_valid;
  logic  imemory_instr;
  word_t imemory_addr;
  word_t imemory_wdata;
  strb_t imemory_wstrb;
  word_t imemory_rdata;
  logic  imemory_ready;
  logic  dmemory_valid;
  logic  dmemory_instr;
  word_t dmemory_addr;
  word_t dmemory_wdata;
  strb_t dmemory_wstrb;
  word_t dmemory_rdata;
  logic  dmemory_ready;

  word_t mem [0 : 1023];
  word_t prog [$];
  word_t got_addr [$];
  strb_t got_strb [$];
  word_t got_data [$];
  word_t exp_addr [$];
  strb_t exp_strb [$];
  word_t exp_data [$];
  logic  marker_seen;
  logic  slow_memory = 1'b0;
  int    store_off;
  int    errors = 0;

  always #5 clock = ~clock;

  cpu cpu_inst (.*);

  function automatic word_t fill_word(input word_t addr);
    return addr * 32'h9e37_79b1 + 32'h0bad_f00d;
  endfunction

  function automatic int pick_delay();
    if (slow_memory) begin
      return 3;
    end
    return int'($urandom_range(3, 0));
  endfunction

  function automatic word_t enc_r(input logic [6 : 0] funct7, input int rs2, input int rs1,
                                  input logic [2 : 0] funct3, input int rd);
    return {funct7, 5'(rs2), 5'(rs1), funct3, 5'(rd), 7'b0110011};
  endfunction

  function automatic word_t enc_i(input int imm, input int rs1, input logic [2 : 0] funct3,
                                  input int rd, input logic [6 : 0] opcode);
    return {12'(imm), 5'(rs1), funct3, 5'(rd), opcode};
  endfunction

  function automatic word_t enc_s(input int imm, input int rs2, input int rs1,
                                  input logic [2 : 0] funct3);
    logic [11 : 0] i;
    i = 12'(imm);
    return {i[11 : 5], 5'(rs2), 5'(rs1), funct3, i[4 : 0], 7'b0100011};
  endfunction

  function automatic word_t enc_b(input int imm, input int rs2, input int rs1,
                                  input logic [2 : 0] funct3);
    logic [12 : 0] i;
    i = 13'(imm);
    return {i[12], i[10 : 5], 5'(rs2), 5'(rs1), funct3, i[4 : 1], i[11], 7'b1100011};
  endfunction

  function automatic word_t enc_u(input int imm20, input int rd);
    return {20'(imm20), 5'(rd), 7'b0110111};
  endfunction

  function automatic word_t enc_j(input int imm, input int rd);
    logic [20 : 0] i;
    i = 21'(imm);
    return {i[20], i[10 : 1], i[11], i[19 : 12], 5'(rd), 7'b1101111};
  endfunction

  task automatic emit(input word_t w);
    prog.push_back(w);
  endtask

  task automatic expect_store(input word_t addr, input strb_t strb, input word_t data);
    exp_addr.push_back(addr);
    exp_strb.push_back(strb);
    exp_data.push_back(data);
  endtask

  // sw rs2 to the next result slot above x10.
  task automatic store_word(input int rs2, input word_t value);
    emit(enc_s(store_off, rs2, 10, 3'b010));
    expect_store(data_base + word_t'(store_off), 4'b1111, value);
    store_off += 4;
  endtask

  task automatic alu_step(input word_t w, input word_t value);
    emit(w);
    store_word(4, value);
  endtask

  task automatic begin_program();
    prog.delete();
    exp_addr.delete();
    exp_strb.delete();
    exp_data.delete();
    store_off = 0;
    emit(enc_i(int'(data_base), 0, 3'b000, 10, opc_imm));
  endtask

  task automatic check_value(input string what, input word_t got, input word_t expected);
    if (got !== expected) begin
      $display("mismatch %s: got %h expected %h", what, got, expected);
      errors++;
    end
  endtask

  task automatic compare_stores(input string name);
    int n;
    int i;
    n = got_addr.size();
    if (n > exp_addr.size()) begin
      $display("%s made %0d more stores than expected", name, n - exp_addr.size());
      errors++;
      n = exp_addr.size();
    end else if (n < exp_addr.size()) begin
      $display("%s is missing %0d expected stores", name, exp_addr.size() - n);
      errors++;
    end
    for (i = 0; i < n; i++) begin
      check_value($sformatf("dmemory_addr in %s store %0d", name, i), got_addr[i], exp_addr[i]);
      check_value($sformatf("dmemory_wstrb in %s store %0d", name, i),
                  word_t'(got_strb[i]), word_t'(exp_strb[i]));
      check_value($sformatf("dmemory_wdata in %s store %0d", name, i), got_data[i], exp_data[i]);
    end
  endtask

  task automatic run_program(input string name);
    int i;
    emit(enc_u(1, 31)); // marker store to 0xffc, then spin.
    emit(enc_s(-4, 0, 31, 3'b010));
    emit(enc_j(0, 0));
    @(negedge clock);
    arst_n = 1'b0;
    repeat (5) @(negedge clock);
    for (i = 0; i < 1024; i++) begin
      mem[i] = fill_word(word_t'(i) << 2);
    end
    for (i = 0; i < prog.size(); i++) begin
      mem[i] = prog[i];
    end
    got_addr.delete();
    got_strb.delete();
    got_data.delete();
    marker_seen = 1'b0;
    arst_n = 1'b1;
    @(negedge clock);
    check_value("imemory_valid after reset", word_t'(imemory_valid), 32'd1);
    check_value("imemory_instr after reset", word_t'(imemory_instr), 32'd1);
    check_value("imemory_addr after reset", imemory_addr, reset_vector);
    check_value("dmemory_valid after reset", word_t'(dmemory_valid), 32'd0);
    while (!marker_seen) begin
      @(negedge clock);
    end
    compare_stores(name);
  endtask

  task automatic test_alu(input logic slow);
    word_t a;
    word_t b;
    word_t c;
    a = 32'hffff_ffec; // -20.
    b = 32'd5;
    c = 32'h8765_4321;
    slow_memory = slow;
    begin_program();
    emit(enc_i(-20, 0, 3'b000, 1, opc_imm));
    emit(enc_i(5, 0, 3'b000, 2, opc_imm));
    emit(enc_u(32'h87654, 3));
    emit(enc_i(32'h321, 3, 3'b000, 3, opc_imm));
    alu_step(enc_r(7'h00, 2, 1, 3'b000, 4), a + b);
    alu_step(enc_r(7'h20, 2, 1, 3'b000, 4), a - b);
    alu_step(enc_r(7'h00, 1, 3, 3'b111, 4), c & a);
    alu_step(enc_r(7'h00, 2, 3, 3'b110, 4), c | b);
    alu_step(enc_r(7'h00, 1, 3, 3'b100, 4), c ^ a);
    alu_step(enc_r(7'h00, 2, 1, 3'b010, 4), 32'd1); // -20 below 5 when signed.
    alu_step(enc_r(7'h00, 2, 1, 3'b011, 4), 32'd0); // but not when unsigned.
    alu_step(enc_r(7'h00, 1, 2, 3'b010, 4), 32'd0);
    alu_step(enc_r(7'h00, 1, 2, 3'b011, 4), 32'd1);
    alu_step(enc_r(7'h00, 2, 3, 3'b001, 4), c * 32'd32); // shift amount in x2 is 5.
    alu_step(enc_r(7'h00, 2, 3, 3'b101, 4), c / 32'd32);
    alu_step(enc_r(7'h20, 2, 3, 3'b101, 4), (c / 32'd32) | ~(32'hffff_ffff / 32'd32));
    alu_step(enc_r(7'h20, 2, 1, 3'b101, 4), (a / 32'd32) | ~(32'hffff_ffff / 32'd32));
    alu_step(enc_i(-100, 3, 3'b000, 4, opc_imm), c + word_t'(-100));
    alu_step(enc_i(32'h0ff, 3, 3'b111, 4, opc_imm), c & 32'h0000_00ff);
    alu_step(enc_i(32'h555, 1, 3'b110, 4, opc_imm), a | 32'h0000_0555);
    alu_step(enc_i(-1, 3, 3'b100, 4, opc_imm), ~c);
    alu_step(enc_i(-19, 1, 3'b010, 4, opc_imm), 32'd1);
    alu_step(enc_i(7, 1, 3'b011, 4, opc_imm), 32'd0);
    alu_step(enc_i(-1, 2, 3'b011, 4, opc_imm), 32'd1); // -1 extends to the largest value.
    alu_step(enc_i(7, 3, 3'b001, 4, opc_imm), c * 32'd128);
    alu_step(enc_i(13, 3, 3'b101, 4, opc_imm), c / 32'd8192);
    alu_step(enc_i(32'h400 | 13, 3, 3'b101, 4, opc_imm),
             (c / 32'd8192) | ~(32'hffff_ffff / 32'd8192));
    run_program(slow ? "alu slow" : "alu");
  endtask

  task automatic test_bytes();
    word_t w;
    begin_program();
    emit(enc_i(32'h0a5, 0, 3'b000, 1, opc_imm));
    emit(enc_i(32'h13c, 0, 3'b000, 2, opc_imm));
    emit(enc_s(1, 1, 10, 3'b000)); // sb to byte lane 1.
    expect_store(data_base, 4'b0001 << 1, {4{8'ha5}});
    emit(enc_s(3, 2, 10, 3'b000));
    expect_store(data_base, 4'b0001 << 3, {4{8'h3c}});
    store_off = 16;
    emit(enc_i(1, 10, 3'b000, 4, opc_load));
    store_word(4, {{24{1'b1}}, 8'ha5});
    emit(enc_i(1, 10, 3'b100, 4, opc_load));
    store_word(4, {24'b0, 8'ha5});
    emit(enc_i(3, 10, 3'b000, 4, opc_load));
    store_word(4, {24'b0, 8'h3c});
    w = fill_word(data_base);
    w[15 : 8] = 8'ha5;
    w[31 : 24] = 8'h3c;
    emit(enc_i(0, 10, 3'b010, 4, opc_load));
    store_word(4, w);
    run_program("bytes");
  endtask

  // branch over one marker store, which must show up only when not taken.
  task automatic branch_case(input word_t w, input logic taken);
    emit(w);
    emit(enc_s(store_off, 5, 10, 3'b010));
    if (!taken) begin
      expect_store(data_base + word_t'(store_off), 4'b1111, 32'h11);
    end
    store_off += 4;
  endtask

  task automatic test_branches();
    int r1;
    int r2;
    int r3;
    word_t link;
    r1 = 7;
    r2 = 7;
    r3 = 9;
    begin_program();
    emit(enc_i(r1, 0, 3'b000, 1, opc_imm));
    emit(enc_i(r2, 0, 3'b000, 2, opc_imm));
    emit(enc_i(r3, 0, 3'b000, 3, opc_imm));
    emit(enc_i(32'h11, 0, 3'b000, 5, opc_imm));
    branch_case(enc_b(8, 2, 1, 3'b000), r1 == r2);
    branch_case(enc_b(8, 3, 1, 3'b000), r1 == r3);
    branch_case(enc_b(8, 3, 1, 3'b001), r1 != r3);
    branch_case(enc_b(8, 2, 1, 3'b001), r1 != r2);
    link = word_t'(4 * prog.size() + 4);
    emit(enc_j(12, 6));
    emit(enc_s(100, 5, 10, 3'b010)); // both skipped by the jal.
    emit(enc_s(104, 5, 10, 3'b010));
    store_word(6, link);
    emit(enc_i(3, 0, 3'b000, 7, opc_imm));
    emit(enc_i(1, 8, 3'b000, 8, opc_imm)); // loop body.
    emit(enc_i(-1, 7, 3'b000, 7, opc_imm));
    emit(enc_b(-8, 0, 7, 3'b001));
    store_word(7, 32'd0);
    store_word(8, 32'd3);
    run_program("branches");
  endtask

  task automatic test_lui_x0();
    begin_program();
    emit(enc_u(32'habcde, 1));
    store_word(1, word_t'(32'habcde) << 12);
    emit(enc_u(32'hfffff, 2));
    emit(enc_i(32'h7ff, 2, 3'b000, 2, opc_imm));
    store_word(2, (word_t'(32'hfffff) << 12) + 32'h7ff);
    emit(enc_i(55, 0, 3'b000, 0, opc_imm));
    store_word(0, 32'd0);
    emit(enc_u(32'h12345, 0));
    emit(enc_r(7'h00, 0, 0, 3'b000, 3));
    store_word(3, 32'd0);
    emit(enc_i(-1, 0, 3'b000, 4, opc_imm));
    emit(enc_r(7'h00, 4, 0, 3'b000, 5));
    store_word(5, 32'hffff_ffff);
    run_program("lui and x0");
  endtask

  // shared memory model with ready after 0 to 3 cycles.
  initial begin
    int iwait;
    int dwait;
    int k;
    logic [9 : 0] idx;
    void'($urandom(32'h7988ff4b));
    iwait = 0;
    dwait = 0;
    forever begin
      @(negedge clock);
      if (imemory_valid && !imemory_ready) begin
        if (iwait == 0) begin
          check_value("imemory_wstrb on fetch", word_t'(imemory_wstrb), 32'd0);
          imemory_rdata = mem[imemory_addr[11 : 2]];
          imemory_ready = 1'b1;
        end else begin
          iwait--;
        end
      end else begin
        imemory_ready = 1'b0;
        iwait = pick_delay();
      end
      if (dmemory_valid && !dmemory_ready) begin
        if (dwait == 0) begin
          check_value("dmemory_instr on data access", word_t'(dmemory_instr), 32'd0);
          idx = dmemory_addr[11 : 2];
          if (dmemory_wstrb == '0) begin
            dmemory_rdata = mem[idx];
          end else if (dmemory_addr == marker_addr) begin
            marker_seen = 1'b1;
          end else begin
            got_addr.push_back(dmemory_addr);
            got_strb.push_back(dmemory_wstrb);
            got_data.push_back(dmemory_wdata);
            for (k = 0; k < 4; k++) begin
              if (dmemory_wstrb[k]) begin
                mem[idx][8 * k +: 8] = dmemory_wdata[8 * k +: 8];
              end
            end
          end
          dmemory_ready = 1'b1;
        end else begin
          dwait--;
        end
      end else begin
        dmemory_ready = 1'b0;
        dwait = pick_delay();
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: no marker store seen within %0d ns", watchdog_ns);
    errors++;
    $display("errors: %0d", errors);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    arst_n = 1'b0;
    imemory_rdata = '0;
    imemory_ready = 1'b0;
    dmemory_rdata = '0;
    dmemory_ready = 1'b0;
    marker_seen = 1'b0;
    test_alu(1'b0);
    test_bytes();
    test_branches();
    test_lui_x0();
    test_alu(1'b1); // ready always at its latest.
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
verilog/configure.sv
verilog/mem_if.sv
verilog/decode_if.sv
verilog/decoder.sv
verilog/alu.sv
verilog/register.sv
verilog/lsu.sv
verilog/sequencer.sv
verilog/cpu.sv
verif/cpu_props.sv
verif/cpu_tb.sv

/* Makefile */
SOURCES := $(wildcard verilog/*.sv verif/*.sv)

.PHONY: all lint clean

all: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb > sim.log 2>&1; cat sim.log
	@if grep -q "Test FAILED" sim.log; then exit 1; fi
	@grep -q "Test OK" sim.log

obj_dir/Vcpu_tb: sim.f $(SOURCES)
	verilator --binary --timing --assert --top-module cpu_tb -f sim.f

lint:
	verilator --lint-only -Wall --timing --assert --top-module cpu_tb -f sim.f

clean:
	rm -rf obj_dir sim.log
